//--- ex_pkg.sv
package ex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 6;

  ////////////////////////////////////////
  // Opcodes and selects
  ////////////////////////////////////////

  // Unified opcode as issued by decode in ID
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_MUL, OP_MAC, OP_MULH, OP_MULHU,
    OP_CSR, OP_LSU, OP_NOP
  } ex_op_e;

  // ALU operation, compares share the encoding space with arithmetic
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    MULT_MUL, MULT_MAC, MULT_MULH, MULT_MULHU
  } mult_op_e;

  // Source of the forwarded result
  typedef enum logic [2:0] {
    UNIT_NONE, UNIT_ALU, UNIT_MULT, UNIT_CSR, UNIT_LSU
  } unit_sel_e;

  // High-half multiply sequencer
  typedef enum logic [1:0] {
    MS_IDLE, MS_LOW, MS_HIGH
  } mult_state_e;

  ////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////

  // One issued instruction from ID
  typedef struct packed {
    logic                  en;
    ex_op_e                op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       operand_c;
    // Forwarding port destination
    logic                  alu_we;
    logic [REG_ADDR_W-1:0] alu_waddr;
    // Passed through to WB for loads
    logic                  lsu_we;
    logic [REG_ADDR_W-1:0] lsu_waddr;
  } ex_issue_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } ex_fw_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } ex_wb_t;

endpackage

//--- ex_decode.sv
`timescale 1ns/100ps

module ex_decode (
  input  ex_pkg::ex_issue_t issue_i,
  output ex_pkg::unit_sel_e unit_sel_o,
  output ex_pkg::alu_op_e   alu_op_o,
  output ex_pkg::mult_op_e  mult_op_o,
  output logic              branch_o
);

  import ex_pkg::*;

  // Opcode to ALU operation
  always_comb begin
    case (issue_i.op)
      OP_SUB:  alu_op_o = ALU_SUB;
      OP_AND:  alu_op_o = ALU_AND;
      OP_OR:   alu_op_o = ALU_OR;
      OP_XOR:  alu_op_o = ALU_XOR;
      OP_SLL:  alu_op_o = ALU_SLL;
      OP_SRL:  alu_op_o = ALU_SRL;
      OP_SRA:  alu_op_o = ALU_SRA;
      OP_SLT:  alu_op_o = ALU_SLT;
      OP_SLTU: alu_op_o = ALU_SLTU;
      OP_BEQ:  alu_op_o = ALU_EQ;
      OP_BNE:  alu_op_o = ALU_NE;
      OP_BLT:  alu_op_o = ALU_LT;
      OP_BGE:  alu_op_o = ALU_GE;
      OP_BLTU: alu_op_o = ALU_LTU;
      OP_BGEU: alu_op_o = ALU_GEU;
      default: alu_op_o = ALU_ADD;
    endcase
  end

  // Opcode to multiplier operation, only meaningful with UNIT_MULT
  always_comb begin
    case (issue_i.op)
      OP_MAC:   mult_op_o = MULT_MAC;
      OP_MULH:  mult_op_o = MULT_MULH;
      OP_MULHU: mult_op_o = MULT_MULHU;
      default:  mult_op_o = MULT_MUL;
    endcase
  end

  // Unit select and branch flag, both dead without an enabled issue
  always_comb begin
    unit_sel_o = UNIT_NONE;
    branch_o   = 1'b0;
    if (issue_i.en) begin
      case (issue_i.op)
        OP_MUL, OP_MAC, OP_MULH, OP_MULHU: unit_sel_o = UNIT_MULT;
        OP_CSR:                           unit_sel_o = UNIT_CSR;
        OP_LSU:                           unit_sel_o = UNIT_LSU;
        OP_NOP:                           unit_sel_o = UNIT_NONE;
        default:                          unit_sel_o = UNIT_ALU;
      endcase
      // Compares resolve in EX and release the stage early
      branch_o = issue_i.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    end
  end

  // Select only resolves to the intended unit for a known opcode
  always_comb begin
    a_sel_known: assert final (!issue_i.en || !$isunknown(issue_i.op));
  end

endmodule

//--- ex_alu.sv
`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_op_e         alu_op_i,
  input  logic [ex_pkg::XLEN-1:0] operand_a_i,
  input  logic [ex_pkg::XLEN-1:0] operand_b_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    cmp_result_o
);

  import ex_pkg::*;

  logic [4:0]      shamt;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            is_eq;
  logic            lt_signed;
  logic            lt_unsigned;

  ////////////////////////////////////////
  // Shared datapath
  ////////////////////////////////////////

  // RV32 shifts only look at the low five bits
  assign shamt = operand_b_i[4:0];

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Comparator feeds both SLT and the branch decision
  assign is_eq       = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  ////////////////////////////////////////
  // Compare result
  ////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      ALU_EQ:           cmp_result_o = is_eq;
      ALU_NE:           cmp_result_o = !is_eq;
      ALU_LT, ALU_SLT:  cmp_result_o = lt_signed;
      ALU_GE:           cmp_result_o = !lt_signed;
      ALU_LTU, ALU_SLTU: cmp_result_o = lt_unsigned;
      ALU_GEU:          cmp_result_o = !lt_unsigned;
      // Non-compare ops never take a branch
      default:          cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA: result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // SLT and the branch compares put the flag in bit 0
      default: result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

//--- ex_mult.sv
`timescale 1ns/100ps

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    en_i,
  input  ex_pkg::mult_op_e        mult_op_i,
  input  logic [ex_pkg::XLEN-1:0] operand_a_i,
  input  logic [ex_pkg::XLEN-1:0] operand_b_i,
  input  logic [ex_pkg::XLEN-1:0] operand_c_i,
  input  logic                    ex_ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    ready_o,
  output logic                    multicycle_o
);

  import ex_pkg::*;

  mult_state_e       state_q;
  mult_state_e       state_d;
  logic              high_op;
  logic              is_signed;
  logic [XLEN-1:0]   prod_lo;
  logic signed [32:0] a_ext;
  logic signed [16:0] b_lo_ext;
  logic signed [16:0] b_hi_ext;
  logic signed [49:0] pp_lo;
  logic signed [49:0] pp_hi;
  logic [63:0]       pp_lo_q;
  logic [63:0]       high_sum;

  ////////////////////////////////////////
  // Single-cycle MUL and MAC
  ////////////////////////////////////////

  // Low 32 bits do not depend on signedness
  assign prod_lo = operand_a_i * operand_b_i;

  ////////////////////////////////////////
  // High-half partial products
  ////////////////////////////////////////

  assign high_op   = (mult_op_i == MULT_MULH) || (mult_op_i == MULT_MULHU);
  assign is_signed = (mult_op_i == MULT_MULH);

  // One extra bit makes the unsigned case fit a signed multiply
  assign a_ext    = {is_signed & operand_a_i[31], operand_a_i};
  assign b_lo_ext = {1'b0, operand_b_i[15:0]};
  assign b_hi_ext = {is_signed & operand_b_i[31], operand_b_i[31:16]};

  assign pp_lo = a_ext * b_lo_ext;
  assign pp_hi = a_ext * b_hi_ext;

  // Modulo 2^64 sum is exact for both signed and unsigned products
  assign high_sum = pp_lo_q + ({{14{pp_hi[49]}}, pp_hi} << 16);

  // Low partial product, payload only
  always_ff @(posedge clk) begin
    if (state_q == MS_LOW) begin
      pp_lo_q <= {{14{pp_lo[49]}}, pp_lo};
    end
  end

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MS_IDLE: if (en_i && high_op) state_d = MS_LOW;
      MS_LOW:  state_d = MS_HIGH;
      // Hold the high half until EX is released
      MS_HIGH: if (ex_ready_i) state_d = MS_IDLE;
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Stall through IDLE and LOW of a high-half op
  assign ready_o      = (state_q == MS_HIGH) || ((state_q == MS_IDLE) && !(en_i && high_op));
  assign multicycle_o = (state_q == MS_HIGH);

  always_comb begin
    if (state_q == MS_HIGH) begin
      result_o = high_sum[63:32];
    end else if (mult_op_i == MULT_MAC) begin
      result_o = prod_lo + operand_c_i;
    end else begin
      result_o = prod_lo;
    end
  end

  // Issuer must hold the op while the sequencer works on it
  a_op_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != MS_IDLE) |-> $stable(mult_op_i));

endmodule

//--- ex_result.sv
`timescale 1ns/100ps

module ex_result (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::ex_issue_t       issue_i,
  input  ex_pkg::unit_sel_e       unit_sel_i,
  input  logic                    branch_i,
  input  logic [ex_pkg::XLEN-1:0] alu_result_i,
  input  logic [ex_pkg::XLEN-1:0] mult_result_i,
  input  logic [ex_pkg::XLEN-1:0] csr_rdata_i,
  input  logic [ex_pkg::XLEN-1:0] lsu_rdata_i,
  input  logic                    mult_ready_i,
  input  logic                    lsu_ready_ex_i,
  input  logic                    wb_ready_i,
  output ex_pkg::ex_fw_t          fw_o,
  output ex_pkg::ex_wb_t          wb_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  import ex_pkg::*;

  logic                  units_ready;
  logic                  lsu_we_q;
  logic [REG_ADDR_W-1:0] lsu_waddr_q;

  ////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////

  // Destination comes straight from the issue
  assign fw_o.we    = issue_i.alu_we;
  assign fw_o.waddr = issue_i.alu_waddr;

  always_comb begin
    case (unit_sel_i)
      UNIT_ALU:  fw_o.wdata = alu_result_i;
      UNIT_MULT: fw_o.wdata = mult_result_i;
      UNIT_CSR:  fw_o.wdata = csr_rdata_i;
      // Loads return through the WB port
      default:   fw_o.wdata = '0;
    endcase
  end

  ////////////////////////////////////////
  // Stall control
  ////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX and need no WB slot
  assign ex_ready_o = units_ready | branch_i;
  assign ex_valid_o = issue_i.en & (unit_sel_i != UNIT_NONE) & units_ready;

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_q <= issue_i.lsu_we;
    end else if (wb_ready_i) begin
      // WB drained it and nothing new came in, so flush
      lsu_we_q <= 1'b0;
    end
  end

  // Address is payload, only loaded with a write
  always_ff @(posedge clk) begin
    if (ex_valid_o && issue_i.lsu_we) begin
      lsu_waddr_q <= issue_i.lsu_waddr;
    end
  end

  // Load data arrives from the LSU in the WB cycle
  assign wb_o.we    = lsu_we_q;
  assign wb_o.waddr = lsu_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

  // A write reaches WB only from an accepted load
  a_wb_from_valid: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_o.we) |-> $past(ex_valid_o && (unit_sel_i == UNIT_LSU)));

endmodule

//--- ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::ex_issue_t       issue_i,
  input  logic [ex_pkg::XLEN-1:0] csr_rdata_i,
  input  logic [ex_pkg::XLEN-1:0] lsu_rdata_i,
  input  logic                    lsu_ready_ex_i,
  input  logic                    wb_ready_i,
  output ex_pkg::ex_fw_t          fw_o,
  output ex_pkg::ex_wb_t          wb_o,
  output logic                    branch_decision_o,
  output logic [ex_pkg::XLEN-1:0] jump_target_o,
  output logic                    mult_multicycle_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  import ex_pkg::*;

  unit_sel_e       unit_sel;
  alu_op_e         alu_op;
  mult_op_e        mult_op;
  logic            branch_in_ex;
  logic [XLEN-1:0] alu_result;
  logic            cmp_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  ////////////////////////////////////////
  // Decode and functional units
  ////////////////////////////////////////

  ex_decode u_decode (
    .issue_i    (issue_i),
    .unit_sel_o (unit_sel),
    .alu_op_o   (alu_op),
    .mult_op_o  (mult_op),
    .branch_o   (branch_in_ex)
  );

  ex_alu u_alu (
    .alu_op_i     (alu_op),
    .operand_a_i  (issue_i.operand_a),
    .operand_b_i  (issue_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (cmp_result)
  );

  // Sequencer steps out of HIGH only once the stage is released
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (unit_sel == UNIT_MULT),
    .mult_op_i    (mult_op),
    .operand_a_i  (issue_i.operand_a),
    .operand_b_i  (issue_i.operand_b),
    .operand_c_i  (issue_i.operand_c),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////
  // Result, WB register and stall
  ////////////////////////////////////////

  ex_result u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_i        (issue_i),
    .unit_sel_i     (unit_sel),
    .branch_i       (branch_in_ex),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .csr_rdata_i    (csr_rdata_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .fw_o           (fw_o),
    .wb_o           (wb_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  // Branch outcome and target back to fetch
  assign branch_decision_o = cmp_result;
  assign jump_target_o     = issue_i.operand_c;

endmodule

//--- tb_ex_model.svh
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

////////////////////////////////////////
// Reference model
////////////////////////////////////////

function automatic logic is_branch(input ex_op_e op);
  return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
endfunction

function automatic logic is_high_mult(input ex_op_e op);
  return (op == OP_MULH) || (op == OP_MULHU);
endfunction

// Two's complement compare built from the sign bits
function automatic logic signed_lt(input logic [31:0] a, input logic [31:0] b);
  return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic logic [31:0] model_alu(input ex_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_AND:  return a & b;
    OP_OR:   return a | b;
    OP_XOR:  return a ^ b;
    OP_SLL:  return a << sh;
    OP_SRL:  return a >> sh;
    // Fill the vacated top bits with the sign
    OP_SRA:  return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
    OP_SLT:  return {31'b0, signed_lt(a, b)};
    OP_SLTU: return {31'b0, a < b};
    default: return 32'h0;
  endcase
endfunction

function automatic logic model_cmp(input ex_op_e op, input logic [31:0] a,
                                   input logic [31:0] b);
  case (op)
    OP_BEQ:  return a == b;
    OP_BNE:  return a != b;
    OP_BLT:  return signed_lt(a, b);
    OP_BGE:  return !signed_lt(a, b);
    OP_BLTU: return a < b;
    OP_BGEU: return !(a < b);
    default: return 1'b0;
  endcase
endfunction

// Full 64 bit product, sign extension makes MULH exact modulo 2^64
function automatic logic [31:0] model_mult(input ex_op_e op, input logic [31:0] a,
                                           input logic [31:0] b, input logic [31:0] c);
  logic [63:0] ua;
  logic [63:0] ub;
  logic [63:0] prod;
  if (op == OP_MULH) begin
    ua = {{32{a[31]}}, a};
    ub = {{32{b[31]}}, b};
  end else begin
    ua = {32'b0, a};
    ub = {32'b0, b};
  end
  prod = ua * ub;
  case (op)
    OP_MAC:              return prod[31:0] + c;
    OP_MULH, OP_MULHU:   return prod[63:32];
    default:             return prod[31:0];
  endcase
endfunction

function automatic logic [31:0] model_fw_data(input ex_issue_t iss, input logic [31:0] csr);
  if (iss.op inside {OP_MUL, OP_MAC, OP_MULH, OP_MULHU}) begin
    return model_mult(iss.op, iss.operand_a, iss.operand_b, iss.operand_c);
  end else if (iss.op == OP_CSR) begin
    return csr;
  end
  return model_alu(iss.op, iss.operand_a, iss.operand_b);
endfunction

////////////////////////////////////////
// Expected state
////////////////////////////////////////

logic       exp_wb_we;
logic [5:0] exp_wb_waddr;
// Rising edges seen since the current issue appeared
int         op_age;

task automatic reset_model();
  exp_wb_we = 1'b0;
  op_age    = 0;
endtask

// Called right after a rising edge with the values of the cycle before it
task automatic advance_model(input ex_issue_t iss, input logic ready, input logic valid,
                             input logic wb_rdy);
  if (valid) begin
    exp_wb_we = iss.lsu_we;
    if (iss.lsu_we) begin
      exp_wb_waddr = iss.lsu_waddr;
    end
  end else if (wb_rdy) begin
    exp_wb_we = 1'b0;
  end
  // A new op starts counting after acceptance
  if (ready) begin
    op_age = 0;
  end else if (op_age < 3) begin
    op_age++;
  end
endtask

`endif

//--- tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam int N_ALU        = 60;
  localparam int N_BRANCH     = 30;
  localparam int N_MULT       = 40;
  localparam int N_CSR_LSU    = 40;
  localparam int N_MIXED      = 100;
  localparam int N_OPS        = N_ALU + N_BRANCH + N_MULT + N_CSR_LSU + N_MIXED + 1;
  // Six cycles per op covers a stalled high-half multiply
  localparam int WATCHDOG_CYC = N_OPS * 6 + 40;
  localparam int ACCEPT_LIMIT = 30;

  // How wb_ready and lsu_ready_ex are driven
  localparam int MODE_FREE    = 0;
  localparam int MODE_RANDOM  = 1;
  localparam int MODE_WB_LOW  = 2;

  logic            clk = 1'b0;
  logic            rst_n;
  ex_issue_t       issue;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] lsu_rdata;
  logic            lsu_ready_ex;
  logic            wb_ready;
  ex_fw_t          fw;
  ex_wb_t          wb;
  logic            branch_decision;
  logic [XLEN-1:0] jump_target;
  logic            mult_multicycle;
  logic            ex_ready;
  logic            ex_valid;

  int check_cnt    = 0;
  int mismatch_cnt = 0;
  int failure_cnt  = 0;

  `include "tb_ex_model.svh"

  always #5 clk = ~clk;

  ex_stage uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_i           (issue),
    .csr_rdata_i       (csr_rdata),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .wb_ready_i        (wb_ready),
    .fw_o              (fw),
    .wb_o              (wb),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    check_cnt++;
    assert (got === expected) else begin
      $display("MISMATCH @%0t %s: got %h, expected %h", $time, name, got, expected);
      mismatch_cnt++;
    end
  endtask

  // Compares every output with the model for the inputs of this cycle
  task automatic check_outputs(output logic want_ready, output logic want_valid);
    logic mult_rdy;
    logic units_ok;
    logic is_br;
    logic has_unit;
    logic want_multi;
    mult_rdy   = !(issue.en && is_high_mult(issue.op)) || (op_age >= 2);
    units_ok   = mult_rdy && lsu_ready_ex && wb_ready;
    is_br      = issue.en && is_branch(issue.op);
    has_unit   = issue.en && (issue.op != OP_NOP);
    want_ready = units_ok || is_br;
    want_valid = has_unit && units_ok;
    want_multi = issue.en && is_high_mult(issue.op) && (op_age >= 2);
    compare_value("ex_ready_o", 32'(ex_ready), 32'(want_ready));
    compare_value("ex_valid_o", 32'(ex_valid), 32'(want_valid));
    compare_value("mult_multicycle_o", 32'(mult_multicycle), 32'(want_multi));
    compare_value("fw_o.we", 32'(fw.we), 32'(issue.alu_we));
    compare_value("fw_o.waddr", 32'(fw.waddr), 32'(issue.alu_waddr));
    compare_value("jump_target_o", jump_target, issue.operand_c);
    if (is_br) begin
      compare_value("branch_decision_o", 32'(branch_decision),
                    32'(model_cmp(issue.op, issue.operand_a, issue.operand_b)));
    end
    // Data only matters for a valid op that writes through the forwarding port
    if (want_valid && !is_branch(issue.op) && (issue.op != OP_LSU)) begin
      compare_value("fw_o.wdata", fw.wdata, model_fw_data(issue, csr_rdata));
    end
    compare_value("wb_o.we", 32'(wb.we), 32'(exp_wb_we));
    if (exp_wb_we) begin
      compare_value("wb_o.waddr", 32'(wb.waddr), 32'(exp_wb_waddr));
      compare_value("wb_o.wdata", wb.wdata, lsu_rdata);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  function automatic ex_op_e pick_op(input int lo, input int hi);
    logic [31:0] rnd;
    rnd = $urandom_range(hi, lo);
    return ex_op_e'(rnd[4:0]);
  endfunction

  function automatic ex_issue_t random_issue(input ex_op_e op);
    ex_issue_t   iss;
    logic [31:0] rnd;
    rnd           = $urandom;
    iss.en        = 1'b1;
    iss.op        = op;
    iss.operand_a = $urandom;
    // Equal operands now and then so EQ and GE go both ways
    iss.operand_b = (rnd[1:0] == 2'b00) ? iss.operand_a : $urandom;
    iss.operand_c = $urandom;
    iss.alu_we    = rnd[2];
    iss.alu_waddr = rnd[13:8];
    iss.lsu_we    = (op == OP_LSU);
    iss.lsu_waddr = rnd[21:16];
    return iss;
  endfunction

  // Holds one issue on the falling edge until the stage accepts it
  task automatic issue_op(input ex_issue_t iss, input int mode, output int accept_cyc);
    logic   want_ready;
    logic   want_valid;
    logic   got_ready;
    int     cyc;
    bit     done;
    ex_op_e op;
    cyc        = 0;
    done       = 1'b0;
    accept_cyc = -1;
    op         = iss.op;
    while (!done) begin
      @(negedge clk);
      issue     = iss;
      csr_rdata = $urandom;
      lsu_rdata = $urandom;
      case (mode)
        MODE_RANDOM: begin
          wb_ready     = ($urandom % 4) != 0;
          lsu_ready_ex = ($urandom % 4) != 0;
        end
        MODE_WB_LOW: begin
          wb_ready     = 1'b0;
          lsu_ready_ex = 1'b1;
        end
        default: begin
          wb_ready     = 1'b1;
          lsu_ready_ex = 1'b1;
        end
      endcase
      // Let the combinational outputs settle
      #2;
      check_outputs(want_ready, want_valid);
      got_ready = ex_ready;
      @(posedge clk);
      advance_model(iss, want_ready, want_valid, wb_ready);
      // Acceptance follows the stage's own ready at the edge
      if (got_ready === 1'b1) begin
        done       = 1'b1;
        accept_cyc = cyc;
      end else if (cyc >= ACCEPT_LIMIT) begin
        $display("Issue of %s was not accepted within %0d cycles", op.name(), ACCEPT_LIMIT);
        failure_cnt++;
        done = 1'b1;
      end
      cyc++;
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    ex_issue_t iss;
    int        lat;
    void'($urandom(20));
    rst_n        = 1'b0;
    issue        = '0;
    issue.op     = OP_NOP;
    csr_rdata    = '0;
    lsu_rdata    = '0;
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
    reset_model();
    repeat (4) @(posedge clk);
    @(negedge clk);
    compare_value("wb_o.we in reset", 32'(wb.we), 32'd0);
    rst_n = 1'b1;

    // Integer ALU ops
    for (int i = 0; i < N_ALU; i++) begin
      issue_op(random_issue(pick_op(0, 9)), MODE_FREE, lat);
    end
    // Branches release EX with WB blocked
    for (int i = 0; i < N_BRANCH; i++) begin
      issue_op(random_issue(pick_op(10, 15)), MODE_WB_LOW, lat);
    end
    // MUL and MAC in the issue cycle, high halves two cycles later
    for (int i = 0; i < N_MULT; i++) begin
      iss = random_issue(pick_op(16, 19));
      issue_op(iss, MODE_FREE, lat);
      compare_value("ex_valid_o latency", lat, is_high_mult(iss.op) ? 2 : 0);
    end
    // CSR reads and loads
    for (int i = 0; i < N_CSR_LSU; i++) begin
      issue_op(random_issue(pick_op(20, 21)), MODE_FREE, lat);
    end
    // Everything mixed with bubbles and random back-pressure
    for (int i = 0; i < N_MIXED; i++) begin
      iss    = random_issue(pick_op(0, 22));
      iss.en = ($urandom % 8) != 0;
      issue_op(iss, MODE_RANDOM, lat);
    end
    // One bubble so the last load shows on the WB port
    iss    = '0;
    iss.op = OP_NOP;
    issue_op(iss, MODE_FREE, lat);

    $display("Summary: %0d checks, %0d mismatches, %0d other failures",
             check_cnt, mismatch_cnt, failure_cnt);
    if ((mismatch_cnt == 0) && (failure_cnt == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish",
             WATCHDOG_CYC);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- ex_stage.f
+incdir+.
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_mult.sv
ex_result.sv
ex_stage.sv
tb_ex_stage.sv

//--- run.sh
#!/bin/sh
# Compile and run the EX stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f ex_stage.f --top-module tb_ex_stage -o tb_ex_stage
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
exit 0
